// ==== lcd_text_cases.txt ====
# line_a line_b, each 16 characters as 32 hex digits
# first character in the most significant byte
4C434420544558542044524956455220 342D42495420425553204D4F44452020
30313233343536373839414243444546 46454443424139383736353433323130
00000000000000000000000000000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
54454D50203D2032332E352043202020 48554D4944495459203D203431202520
A55A0FF0C33C9669A55A0FF0C33C9669 0123456789ABCDEFFEDCBA9876543210
515549434B2042524F574E20464F5820 4A554D5053204F56455220444F475320
4C494E45204F4E452020202020202020 4C494E452054574F2020202020202020

// ==== verilog.f ====
+incdir+.
lcd_pkg.sv
lcd_frame_sequencer.sv
lcd_bus_writer.sv
lcd_text_top.sv
lcd_text_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lcd text testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module lcd_text_tb \
    -f verilog.f \
    -Mdir obj_dir

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/Vlcd_text_tb

// ==== lcd_text_tb.sv ====
`timescale 1ns/1ps

`include "lcd_settings.svh"

module lcd_text_tb;

    localparam int NIBBLE_CYCLES = `LCD_SETUP_CYCLES + `LCD_E_HIGH_CYCLES + `LCD_HOLD_CYCLES;
    // one full write, strobe cycle included
    localparam int WRITE_CYCLES  = 2 * NIBBLE_CYCLES + `LCD_GAP_CYCLES + 1;
    localparam int INIT_CYCLES   = 4 * (NIBBLE_CYCLES + `LCD_GAP_CYCLES + 1) + 3 * WRITE_CYCLES
                                   + 2 * NIBBLE_CYCLES + `LCD_CLEAR_WAIT_CYCLES + 1;
    localparam int FRAME_CYCLES  = (2 * `LCD_CHARS_PER_LINE + 2) * WRITE_CYCLES;
    localparam int CLEAR_LOW_MIN = `LCD_HOLD_CYCLES + `LCD_CLEAR_WAIT_CYCLES + `LCD_SETUP_CYCLES;
    localparam lcd_pkg::lcd_line_t IDLE_TEXT = {16{8'h20}};

    logic                 clk;
    logic                 rst_n;
    lcd_pkg::lcd_line_t   line_a;
    lcd_pkg::lcd_line_t   line_b;
    logic                 lcd_rs;
    logic                 lcd_rw;
    logic                 lcd_e;
    lcd_pkg::lcd_nibble_t lcd_data;

    lcd_pkg::lcd_line_t   case_a[$];
    lcd_pkg::lcd_line_t   case_b[$];
    // text each frame should show, oldest first
    lcd_pkg::lcd_line_t   shown_a[$];
    lcd_pkg::lcd_line_t   shown_b[$];
    lcd_pkg::lcd_write_t  rx_q[$];
    int                   frame_starts = 0;
    integer               seed = 32'h1498_7d17;

    lcd_text_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .line_a   (line_a),
        .line_b   (line_b),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_e    (lcd_e),
        .lcd_data (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    // lower bound checks show the bound when met
    function automatic int clamp_to(input int value, input int limit);
        return (value < limit) ? value : limit;
    endfunction

    task automatic load_cases();
        integer             fd;
        string              text;
        lcd_pkg::lcd_line_t a;
        lcd_pkg::lcd_line_t b;
        fd = $fopen("lcd_text_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open lcd_text_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 1 && text[0] != "#" && $sscanf(text, "%h %h", a, b) == 2) begin
                    case_a.push_back(a);
                    case_b.push_back(b);
                end
            end
            $fclose(fd);
            if (case_a.size() == 0) begin
                stop_with_failure("lcd_text_cases.txt holds no test cases");
            end
        end
    endtask

    task automatic expect_write(input string name, input logic rs, input lcd_pkg::lcd_byte_t code);
        lcd_pkg::lcd_write_t w;
        while (rx_q.size() == 0) begin
            @(negedge clk);
        end
        w = rx_q.pop_front();
        compare_value({name, " rs"}, rs, w.rs);
        compare_value({name, " code"}, code, w.code);
    endtask

    task automatic check_frame(input int n);
        lcd_pkg::lcd_line_t a;
        lcd_pkg::lcd_line_t b;
        int                 i;
        while (shown_a.size() == 0) begin
            @(negedge clk);
        end
        a = shown_a.pop_front();
        b = shown_b.pop_front();
        expect_write($sformatf("frame %0d line 1 address", n), 1'b0, 8'h80);
        for (i = 0; i < `LCD_CHARS_PER_LINE; i++) begin
            expect_write($sformatf("frame %0d line 1 char %0d", n, i), 1'b1, a[127 - 8 * i -: 8]);
        end
        expect_write($sformatf("frame %0d line 2 address", n), 1'b0, 8'hC0);
        for (i = 0; i < `LCD_CHARS_PER_LINE; i++) begin
            expect_write($sformatf("frame %0d line 2 char %0d", n, i), 1'b1, b[127 - 8 * i -: 8]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus monitor, samples just after each falling clock edge
    ////////////////////////////////////////////////////////////////////////////

    initial begin : bus_monitor
        logic                prev_e;
        logic [4:0]          bus;
        logic [4:0]          prev_bus;
        logic [4:0]          pulse_bus;
        logic                have_high;
        logic [4:0]          high_bus;
        logic                clear_gap;
        int                  e_cnt;
        int                  low_cnt;
        int                  stable_cnt;
        int                  hold_left;
        int                  nibbles;
        int                  run_cycles;
        lcd_pkg::lcd_write_t w;
        prev_e     = 1'b0;
        prev_bus   = '0;
        pulse_bus  = '0;
        have_high  = 1'b0;
        high_bus   = '0;
        clear_gap  = 1'b0;
        e_cnt      = 0;
        low_cnt    = 0;
        stable_cnt = 0;
        hold_left  = 0;
        nibbles    = 0;
        run_cycles = 0;
        forever begin
            @(negedge clk);
            #1;
            bus = {lcd_rs, lcd_data};
            if (!rst_n) begin
                compare_value("lcd_e in reset", 0, lcd_e);
                compare_value("lcd_rs in reset", 0, lcd_rs);
                compare_value("lcd_rw in reset", 0, lcd_rw);
                compare_value("lcd_data in reset", 0, lcd_data);
            end else begin
                run_cycles++;
                compare_value("lcd_rw", 0, lcd_rw);
                if (lcd_e && !prev_e) begin
                    if (nibbles == 0) begin
                        compare_value("cycles before first enable (min)", `LCD_POWER_ON_CYCLES,
                                      clamp_to(run_cycles, `LCD_POWER_ON_CYCLES));
                    end
                    compare_value("setup cycles (min)", `LCD_SETUP_CYCLES,
                                  clamp_to(stable_cnt, `LCD_SETUP_CYCLES));
                    if (clear_gap) begin
                        compare_value("enable low after clear (min)", CLEAR_LOW_MIN,
                                      clamp_to(low_cnt, CLEAR_LOW_MIN));
                        clear_gap = 1'b0;
                    end
                    pulse_bus = bus;
                    e_cnt     = 1;
                end else if (lcd_e) begin
                    compare_value("rs and data while enable high", pulse_bus, bus);
                    e_cnt++;
                end else if (prev_e) begin
                    compare_value("enable pulse width", `LCD_E_HIGH_CYCLES, e_cnt);
                    hold_left = `LCD_HOLD_CYCLES;
                    low_cnt   = 0;
                    nibbles++;
                    w = '0;
                    if (nibbles <= 4) begin
                        // wake-up writes are single nibbles
                        w.rs          = pulse_bus[4];
                        w.nibble_only = 1'b1;
                        w.code        = {4'h0, pulse_bus[3:0]};
                        rx_q.push_back(w);
                    end else if (!have_high) begin
                        have_high = 1'b1;
                        high_bus  = pulse_bus;
                        // first pulse of the 0x80 command opens a frame
                        if (pulse_bus == 5'h08) begin
                            frame_starts++;
                        end
                    end else begin
                        have_high = 1'b0;
                        compare_value("rs equal on both nibbles", high_bus[4], pulse_bus[4]);
                        w.rs   = high_bus[4];
                        w.code = {high_bus[3:0], pulse_bus[3:0]};
                        rx_q.push_back(w);
                        clear_gap = (!w.rs && w.code == 8'h01);
                    end
                end
                if (!lcd_e) begin
                    low_cnt++;
                    if (hold_left > 0) begin
                        compare_value("rs and data hold after enable", pulse_bus, bus);
                        hold_left--;
                    end
                end
            end
            stable_cnt = (bus == prev_bus) ? stable_cnt + 1 : 1;
            prev_bus   = bus;
            prev_e     = lcd_e;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus, checks and watchdog
    ////////////////////////////////////////////////////////////////////////////

    // new text lands somewhere inside the frame after its first enable pulse
    initial begin : case_driver
        int k;
        int offset;
        @(posedge rst_n);
        for (k = 0; k < case_a.size(); k++) begin
            while (frame_starts < k + 1) begin
                @(negedge clk);
            end
            offset = $unsigned($random(seed)) % (FRAME_CYCLES / 2);
            repeat (offset) @(negedge clk);
            line_a = case_a[k];
            line_b = case_b[k];
            shown_a.push_back(case_a[k]);
            shown_b.push_back(case_b[k]);
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = (8 + `LCD_POWER_ON_CYCLES + INIT_CYCLES
                 + 2 * (case_a.size() + 1) * FRAME_CYCLES) * 5 / 4;
        repeat (limit) @(posedge clk);
        stop_with_failure($sformatf("display bus stalled, run not done after %0d cycles", limit));
    end

    initial begin
        int f;
        rst_n  = 1'b0;
        line_a = IDLE_TEXT;
        line_b = IDLE_TEXT;
        load_cases();
        shown_a.push_back(IDLE_TEXT);
        shown_b.push_back(IDLE_TEXT);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        expect_write("wake-up nibble 1", 1'b0, 8'h03);
        expect_write("wake-up nibble 2", 1'b0, 8'h03);
        expect_write("wake-up nibble 3", 1'b0, 8'h03);
        expect_write("wake-up nibble 4", 1'b0, 8'h02);
        expect_write("function set", 1'b0, 8'h28);
        expect_write("entry mode", 1'b0, 8'h06);
        expect_write("display on", 1'b0, 8'h0C);
        expect_write("clear display", 1'b0, 8'h01);

        for (f = 0; f <= case_a.size(); f++) begin
            check_frame(f);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== lcd_text_top.sv ====
`timescale 1ns/1ps

module lcd_text_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lcd_pkg::lcd_line_t   line_a,
    input  lcd_pkg::lcd_line_t   line_b,
    output logic                 lcd_rs,
    output logic                 lcd_rw,
    output logic                 lcd_e,
    output lcd_pkg::lcd_nibble_t lcd_data
);

    // sequencer to writer
    lcd_pkg::lcd_write_t write_bus;
    logic                write_strobe;
    logic                busy;

    lcd_frame_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .line_a       (line_a),
        .line_b       (line_b),
        .busy         (busy),
        .write        (write_bus),
        .write_strobe (write_strobe)
    );

    lcd_bus_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .write        (write_bus),
        .write_strobe (write_strobe),
        .busy         (busy),
        .lcd_rs       (lcd_rs),
        .lcd_rw       (lcd_rw),
        .lcd_e        (lcd_e),
        .lcd_data     (lcd_data)
    );

endmodule

// ==== lcd_bus_writer.sv ====
`timescale 1ns/1ps

`include "lcd_settings.svh"

module lcd_bus_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  lcd_pkg::lcd_write_t write,
    input  logic                write_strobe,
    output logic                busy,
    output logic                lcd_rs,
    output logic                lcd_rw,
    output logic                lcd_e,
    output lcd_pkg::lcd_nibble_t lcd_data
);

    function automatic int max_of(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    localparam int MAX_LOAD = max_of(max_of(max_of(`LCD_SETUP_CYCLES, `LCD_E_HIGH_CYCLES),
                                            max_of(`LCD_HOLD_CYCLES, `LCD_GAP_CYCLES)),
                                     `LCD_CLEAR_WAIT_CYCLES);
    localparam int CNT_W = $clog2(MAX_LOAD + 1);

    // reload values, each phase lasts load + 1 cycles
    localparam logic [CNT_W-1:0] SETUP_LOAD = CNT_W'(`LCD_SETUP_CYCLES - 1);
    localparam logic [CNT_W-1:0] E_LOAD     = CNT_W'(`LCD_E_HIGH_CYCLES - 1);
    localparam logic [CNT_W-1:0] HOLD_LOAD  = CNT_W'(`LCD_HOLD_CYCLES - 1);
    localparam logic [CNT_W-1:0] GAP_LOAD   = CNT_W'(`LCD_GAP_CYCLES - 1);
    localparam logic [CNT_W-1:0] CLEAR_LOAD = CNT_W'(`LCD_CLEAR_WAIT_CYCLES - 1);

    lcd_pkg::bus_state_t  state;
    logic [CNT_W-1:0]     cnt;
    logic                 cnt_done;
    // set once the low nibble is on the bus
    logic                 on_low;

    lcd_pkg::lcd_nibble_t low_code;
    logic                 long_q;

    // never reads the panel
    assign lcd_rw   = 1'b0;
    assign cnt_done = (cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // nibble timing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= lcd_pkg::IDLE;
            cnt      <= '0;
            busy     <= 1'b0;
            on_low   <= 1'b0;
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else begin
            if (state != lcd_pkg::IDLE && !cnt_done) begin
                cnt <= cnt - 1'b1;
            end

            case (state)
                lcd_pkg::IDLE: begin
                    if (write_strobe) begin
                        state  <= lcd_pkg::SETUP;
                        cnt    <= SETUP_LOAD;
                        busy   <= 1'b1;
                        on_low <= write.nibble_only;
                        lcd_rs <= write.rs;
                        // high nibble first unless a wake-up write
                        if (write.nibble_only) begin
                            lcd_data <= write.code[3:0];
                        end else begin
                            lcd_data <= write.code[7:4];
                        end
                    end
                end
                lcd_pkg::SETUP: begin
                    if (cnt_done) begin
                        state <= lcd_pkg::E_HIGH;
                        cnt   <= E_LOAD;
                        lcd_e <= 1'b1;
                    end
                end
                lcd_pkg::E_HIGH: begin
                    if (cnt_done) begin
                        state <= lcd_pkg::HOLD;
                        cnt   <= HOLD_LOAD;
                        lcd_e <= 1'b0;
                    end
                end
                lcd_pkg::HOLD: begin
                    if (cnt_done) begin
                        if (on_low) begin
                            state <= lcd_pkg::GAP;
                            cnt   <= long_q ? CLEAR_LOAD : GAP_LOAD;
                        end else begin
                            state    <= lcd_pkg::SETUP;
                            cnt      <= SETUP_LOAD;
                            on_low   <= 1'b1;
                            lcd_data <= low_code;
                        end
                    end
                end
                lcd_pkg::GAP: begin
                    if (cnt_done) begin
                        state <= lcd_pkg::IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: begin
                    state <= lcd_pkg::IDLE;
                end
            endcase
        end
    end

    // parts of the write still needed after capture
    always_ff @(posedge clk) begin
        if (state == lcd_pkg::IDLE && write_strobe) begin
            low_code <= write.code[3:0];
            long_q   <= write.long_wait;
        end
    end

endmodule

// ==== lcd_frame_sequencer.sv ====
`timescale 1ns/1ps

`include "lcd_settings.svh"

module lcd_frame_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  lcd_pkg::lcd_line_t line_a,
    input  lcd_pkg::lcd_line_t line_b,
    input  logic               busy,
    output lcd_pkg::lcd_write_t write,
    output logic               write_strobe
);

    ////////////////////////////////////////////////////////////////////////////
    // step map
    ////////////////////////////////////////////////////////////////////////////

    // steps 0..7 are init, the rest is one frame that repeats
    localparam int INIT_STEPS   = 8;
    localparam int FRAME_FIRST  = INIT_STEPS;
    localparam int LINE_A_FIRST = FRAME_FIRST + 1;
    localparam int LINE_B_CMD   = LINE_A_FIRST + `LCD_CHARS_PER_LINE;
    localparam int LINE_B_FIRST = LINE_B_CMD + 1;
    localparam int LAST_STEP    = LINE_B_FIRST + `LCD_CHARS_PER_LINE - 1;

    localparam int STEP_W = $clog2(LAST_STEP + 1);
    localparam int CHAR_W = $clog2(`LCD_CHARS_PER_LINE);
    localparam int PWR_W  = $clog2(`LCD_POWER_ON_CYCLES + 1);

    localparam logic [STEP_W-1:0] STEP_FRAME  = STEP_W'(FRAME_FIRST);
    localparam logic [STEP_W-1:0] STEP_A_CHAR = STEP_W'(LINE_A_FIRST);
    localparam logic [STEP_W-1:0] STEP_B_CMD  = STEP_W'(LINE_B_CMD);
    localparam logic [STEP_W-1:0] STEP_B_CHAR = STEP_W'(LINE_B_FIRST);
    localparam logic [STEP_W-1:0] STEP_LAST   = STEP_W'(LAST_STEP);
    localparam logic [PWR_W-1:0]  PWR_DONE    = PWR_W'(`LCD_POWER_ON_CYCLES - 1);

    lcd_pkg::seq_state_t state;
    logic [STEP_W-1:0]   step;
    logic [PWR_W-1:0]    pwr_cnt;

    // text held for the whole frame
    lcd_pkg::lcd_line_t  line_a_q;
    lcd_pkg::lcd_line_t  line_b_q;

    logic [STEP_W-1:0]   a_off;
    logic [STEP_W-1:0]   b_off;
    lcd_pkg::lcd_line_t  a_shift;
    lcd_pkg::lcd_line_t  b_shift;
    lcd_pkg::lcd_write_t next_write;

    ////////////////////////////////////////////////////////////////////////////
    // write content for the current step
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        a_off = step - STEP_A_CHAR;
        b_off = step - STEP_B_CHAR;
        // selected character ends up in the top byte
        a_shift = line_a_q << {a_off[CHAR_W-1:0], 3'b000};
        b_shift = line_b_q << {b_off[CHAR_W-1:0], 3'b000};

        next_write = '0;
        case (step)
            // wake-up nibbles
            STEP_W'(0), STEP_W'(1), STEP_W'(2): begin
                next_write.nibble_only = 1'b1;
                next_write.code        = 8'h03;
            end
            STEP_W'(3): begin
                next_write.nibble_only = 1'b1;
                next_write.code        = 8'h02;
            end
            // function set, 4-bit, two lines
            STEP_W'(4): next_write.code = 8'h28;
            STEP_W'(5): next_write.code = 8'h06;
            STEP_W'(6): next_write.code = 8'h0C;
            STEP_W'(7): begin
                next_write.code      = 8'h01;
                next_write.long_wait = 1'b1;
            end
            // ddram address of each line
            STEP_FRAME: next_write.code = 8'h80;
            STEP_B_CMD: next_write.code = 8'hC0;
            default: begin
                next_write.rs = 1'b1;
                if (step < STEP_B_CMD) begin
                    next_write.code = a_shift[127:120];
                end else begin
                    next_write.code = b_shift[127:120];
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // step control
    ////////////////////////////////////////////////////////////////////////////

    assign write_strobe = (state == lcd_pkg::ISSUE) && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= lcd_pkg::POWER_WAIT;
            step    <= '0;
            pwr_cnt <= '0;
        end else begin
            case (state)
                lcd_pkg::POWER_WAIT: begin
                    pwr_cnt <= pwr_cnt + 1'b1;
                    if (pwr_cnt == PWR_DONE) begin
                        state <= lcd_pkg::ISSUE;
                    end
                end
                lcd_pkg::ISSUE: begin
                    if (!busy) begin
                        state <= lcd_pkg::WAIT_DONE;
                        if (step == STEP_LAST) begin
                            step <= STEP_FRAME;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                // next write is loaded here, writer is busy meanwhile
                lcd_pkg::WAIT_DONE: begin
                    state <= lcd_pkg::ISSUE;
                end
                default: begin
                    state <= lcd_pkg::POWER_WAIT;
                end
            endcase
        end
    end

    // frame text and the write waiting for the bus
    always_ff @(posedge clk) begin
        if (write_strobe && step == STEP_FRAME) begin
            line_a_q <= line_a;
            line_b_q <= line_b;
        end
        if (state != lcd_pkg::ISSUE) begin
            write <= next_write;
        end
    end

endmodule

// ==== lcd_pkg.sv ====
package lcd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus and text widths
    ////////////////////////////////////////////////////////////////////////////

    // one 4-bit transfer on the panel bus
    typedef logic [3:0] lcd_nibble_t;

    // command or character code
    typedef logic [7:0] lcd_byte_t;

    // 16 ascii characters, first one in the top byte
    typedef logic [127:0] lcd_line_t;

    ////////////////////////////////////////////////////////////////////////////
    // one write handed from the sequencer to the bus writer
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // 0 command, 1 character
        logic rs;
        // wake-up writes, low nibble only
        logic nibble_only;
        // clear display needs the long wait
        logic long_wait;
        lcd_byte_t code;
    } lcd_write_t;

    ////////////////////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        POWER_WAIT,
        ISSUE,
        WAIT_DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        E_HIGH,
        HOLD,
        GAP
    } bus_state_t;

endpackage

// ==== lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// all delays in clock cycles, scaled down for simulation

// wait after reset before the first write
`define LCD_POWER_ON_CYCLES 40

// rs and data valid with e low before e rises
`define LCD_SETUP_CYCLES 2

// enable pulse width
`define LCD_E_HIGH_CYCLES 4

// data kept after e falls
`define LCD_HOLD_CYCLES 2

// gap after an ordinary write
`define LCD_GAP_CYCLES 6

// gap after clear display
`define LCD_CLEAR_WAIT_CYCLES 30

`define LCD_CHARS_PER_LINE 16

`endif
